// ==== source/cc_capture_cfg.svh ====
// Build-time settings for the capture and feed channel.
// Include in any file that needs the frame depth or the FFT config fields.

`ifndef CC_CAPTURE_CFG_SVH
`define CC_CAPTURE_CFG_SVH

// samples per frame, keep it a power of two
`define CC_RB_DEPTH 64

// FFT scale schedule, two bits per radix-4 stage
// last stage scaled by 2, the rest by 1
`define CC_SCALE_SCHED 16'b01_01_01_01_01_01_01_10

// transform direction, 1 = forward and 0 = inverse
`define CC_FWD 1'b1

`endif

// ==== source/cc_capture_pkg.sv ====
// Shared types for the capture channel: the sample word and the FFT config word.
// Referenced by scoped name from the RTL and the testbench.

`default_nettype none

package cc_capture_pkg;

  // one raw sample from the ADC side
  typedef logic [31:0] sample_t;

  // config word for the FFT core, 24 bits, msb first
  typedef struct packed {
    logic [6:0]  pad;          // core wants these zero
    logic [15:0] scale_sched;  // per-stage scaling
    logic        fwd;          // 1 = forward transform
  } fft_cfg_t;

endpackage

`default_nettype wire

// ==== source/frame_rd_if.sv ====
// One reader's port onto the frozen frame in the ring buffer.
// The reader strobes open and next, and the buffer answers with grant, data and last.

`timescale 1ns/100ps
`default_nettype none

interface frame_rd_if;

  logic                    open;   // session request, one cycle
  logic                    next;   // advance to next sample, one cycle
  logic                    grant;  // session accepted, one cycle
  cc_capture_pkg::sample_t data;   // sample at current position
  logic                    last;   // current sample ends the frame

  modport reader (
    output open,
    output next,
    input  grant,
    input  data,
    input  last
  );

  modport buffer (
    input  open,
    input  next,
    output grant,
    output data,
    output last
  );

endinterface

`default_nettype wire

// ==== source/sample_ring_buffer.sv ====
// Ring buffer of the most recent samples. A trigger freezes it, then one reader
// at a time walks the frozen frame oldest first. A finished cc session unfreezes it.

`timescale 1ns/100ps
`default_nettype none

`include "cc_capture_cfg.svh"

module sample_ring_buffer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cc_capture_pkg::sample_t sample_data,
  input  logic                    sample_valid,
  input  logic                    trigger,
  output logic                    buffer_primed,
  frame_rd_if.buffer              trig_rd,
  frame_rd_if.buffer              cc_rd
);

  localparam int aw = $clog2(`CC_RB_DEPTH);
  localparam logic [aw-1:0] last_idx = aw'(`CC_RB_DEPTH - 1);

  cc_capture_pkg::sample_t mem [`CC_RB_DEPTH];  // sample storage

  logic [aw-1:0] wr_ptr;    // next write slot, also the oldest sample
  logic [aw-1:0] fill_cnt;  // writes since reset, until primed
  logic          frozen;
  logic          active;    // a read session is open
  logic          owner_cc;  // 1 = cc_rd owns the session
  logic [aw-1:0] rd_start;  // oldest slot at session start
  logic [aw-1:0] rd_cnt;    // position within the frame
  logic [aw-1:0] rd_addr;
  logic          wr_en;
  logic          can_open;
  logic          sel_next;  // next from the session owner
  logic          at_last;
  logic          trig_gnt;
  logic          cc_gnt;

  assign wr_en    = sample_valid && !frozen;    // frozen frame is read-only
  assign can_open = frozen && !active;
  assign rd_addr  = rd_start + rd_cnt;          // wraps naturally
  assign at_last  = active && (rd_cnt == last_idx);
  assign sel_next = owner_cc ? cc_rd.next : trig_rd.next;

  // both readers see the same word, last only goes to the owner
  assign trig_rd.data  = mem[rd_addr];
  assign cc_rd.data    = mem[rd_addr];
  assign trig_rd.last  = at_last && !owner_cc;
  assign cc_rd.last    = at_last && owner_cc;
  assign trig_rd.grant = trig_gnt;
  assign cc_rd.grant   = cc_gnt;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= sample_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      fill_cnt      <= '0;
      buffer_primed <= 1'b0;
      frozen        <= 1'b0;
      active        <= 1'b0;
      owner_cc      <= 1'b0;
      rd_start      <= '0;
      rd_cnt        <= '0;
      trig_gnt      <= 1'b0;
      cc_gnt        <= 1'b0;
    end else begin
      trig_gnt <= 1'b0;  // grants are single-cycle
      cc_gnt   <= 1'b0;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (!buffer_primed) begin
          fill_cnt <= fill_cnt + 1'b1;
          if (fill_cnt == last_idx) begin
            buffer_primed <= 1'b1;  // full frame on hand
          end
        end
      end
      if (can_open && trig_rd.open) begin  // trigger path wins a tie
        active   <= 1'b1;
        owner_cc <= 1'b0;
        rd_start <= wr_ptr;
        rd_cnt   <= '0;
        trig_gnt <= 1'b1;
      end else if (can_open && cc_rd.open) begin
        active   <= 1'b1;
        owner_cc <= 1'b1;
        rd_start <= wr_ptr;
        rd_cnt   <= '0;
        cc_gnt   <= 1'b1;
      end else if (active && sel_next) begin
        if (at_last) begin
          active <= 1'b0;  // session done
          if (owner_cc) begin
            frozen <= 1'b0;  // cc consumed the frame
          end
        end else begin
          rd_cnt <= rd_cnt + 1'b1;
        end
      end
      // a fresh trigger re-freezes even on a cc end edge
      if (trigger && buffer_primed) begin
        frozen <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/trigger_streamer.sv ====
// Reads the frozen frame on request and sends it out on the trigger stream.
// count_reached pulses once after the final beat has been taken.

`timescale 1ns/100ps
`default_nettype none

module trigger_streamer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    trig_peek,
  frame_rd_if.reader              rd,
  output cc_capture_pkg::sample_t trig_tdata,
  output logic                    trig_tvalid,
  input  logic                    trig_tready,
  output logic                    count_reached
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,    // open sent, waiting on grant
    st_stream
  } state_t;

  state_t state;
  logic   open_q;
  logic   wait_cnt;  // one extra cycle allowed for grant
  logic   beat_ok;

  assign beat_ok    = trig_tvalid && trig_tready;
  assign rd.open    = open_q;
  assign rd.next    = beat_ok;  // advance only on an accepted beat
  assign trig_tdata = rd.data;  // steady while frozen and not advancing

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= st_idle;
      open_q        <= 1'b0;
      wait_cnt      <= 1'b0;
      trig_tvalid   <= 1'b0;
      count_reached <= 1'b0;
    end else begin
      open_q        <= 1'b0;
      count_reached <= 1'b0;
      case (state)
        st_idle: begin
          if (trig_peek) begin
            open_q   <= 1'b1;
            wait_cnt <= 1'b0;
            state    <= st_wait;
          end
        end
        st_wait: begin
          if (rd.grant) begin
            trig_tvalid <= 1'b1;  // first beat next cycle
            state       <= st_stream;
          end else if (wait_cnt) begin
            state <= st_idle;  // dropped, give up
          end else begin
            wait_cnt <= 1'b1;
          end
        end
        st_stream: begin
          if (beat_ok && rd.last) begin
            trig_tvalid   <= 1'b0;
            count_reached <= 1'b1;  // frame fully delivered
            state         <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/cc_fft_feeder.sv ====
// Feeds one frozen frame into the FFT core. It sends the config word first, then
// the frame, then zero padding if enabled, with tlast on the final beat.

`timescale 1ns/100ps
`default_nettype none

`include "cc_capture_cfg.svh"

module cc_fft_feeder #(
  parameter bit zero_pad = 1'b1  // 1 = double length with zero beats
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start_cc,
  frame_rd_if.reader               rd,
  output cc_capture_pkg::fft_cfg_t cfg_tdata,
  output logic                     cfg_tvalid,
  input  logic                     cfg_tready,
  output cc_capture_pkg::sample_t  fft_tdata,
  output logic                     fft_tvalid,
  input  logic                     fft_tready,
  output logic                     fft_tlast
);

  localparam int total_beats = zero_pad ? 2 * `CC_RB_DEPTH : `CC_RB_DEPTH;
  localparam int cw = $clog2(total_beats);
  localparam logic [cw-1:0] final_beat = cw'(total_beats - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_wait,    // open sent, waiting on grant
    st_config,
    st_frame,   // frozen samples
    st_pad      // zero beats
  } state_t;

  state_t        state;
  logic          open_q;
  logic          wait_cnt;
  logic [cw-1:0] beat_cnt;  // accepted data beats
  logic          beat_ok;

  assign beat_ok = fft_tvalid && fft_tready;

  // constant word, so it holds by itself until taken
  assign cfg_tdata = '{pad: 7'd0, scale_sched: `CC_SCALE_SCHED, fwd: `CC_FWD};

  assign rd.open   = open_q;
  assign rd.next   = beat_ok && (state == st_frame);  // pad beats don't read
  assign fft_tdata = (state == st_frame) ? rd.data : '0;
  assign fft_tlast = fft_tvalid && (beat_cnt == final_beat);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      open_q     <= 1'b0;
      wait_cnt   <= 1'b0;
      beat_cnt   <= '0;
      cfg_tvalid <= 1'b0;
      fft_tvalid <= 1'b0;
    end else begin
      open_q <= 1'b0;
      case (state)
        st_idle: begin
          if (start_cc) begin
            open_q   <= 1'b1;
            wait_cnt <= 1'b0;
            state    <= st_wait;
          end
        end
        st_wait: begin
          if (rd.grant) begin
            cfg_tvalid <= 1'b1;
            beat_cnt   <= '0;
            state      <= st_config;
          end else if (wait_cnt) begin
            state <= st_idle;  // not granted
          end else begin
            wait_cnt <= 1'b1;
          end
        end
        st_config: begin
          if (cfg_tvalid && cfg_tready) begin
            cfg_tvalid <= 1'b0;
            fft_tvalid <= 1'b1;  // data starts next cycle
            state      <= st_frame;
          end
        end
        st_frame: begin
          if (beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (rd.last && zero_pad) begin
              state <= st_pad;
            end else if (rd.last) begin
              fft_tvalid <= 1'b0;
              beat_cnt   <= '0;
              state      <= st_idle;
            end
          end
        end
        st_pad: begin
          if (beat_ok && beat_cnt == final_beat) begin
            fft_tvalid <= 1'b0;  // tlast beat taken
            beat_cnt   <= '0;
            state      <= st_idle;
          end else if (beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/cc_capture_top.sv ====
// Top of the capture and feed channel: ring buffer plus trigger and FFT readers.
// External streams follow valid/ready, and the command inputs are one-cycle strobes.

`timescale 1ns/100ps
`default_nettype none

module cc_capture_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cc_capture_pkg::sample_t  sample_data,
  input  logic                     sample_valid,
  input  logic                     trigger,
  output logic                     buffer_primed,
  input  logic                     trig_peek,
  output cc_capture_pkg::sample_t  trig_tdata,
  output logic                     trig_tvalid,
  input  logic                     trig_tready,
  output logic                     count_reached,
  input  logic                     start_cc,
  output cc_capture_pkg::fft_cfg_t cfg_tdata,
  output logic                     cfg_tvalid,
  input  logic                     cfg_tready,
  output cc_capture_pkg::sample_t  fft_tdata,
  output logic                     fft_tvalid,
  input  logic                     fft_tready,
  output logic                     fft_tlast
);

  frame_rd_if trig_rd ();  // trigger path reader
  frame_rd_if cc_rd ();    // FFT feeder reader

  sample_ring_buffer ring_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .sample_data   (sample_data),
    .sample_valid  (sample_valid),
    .trigger       (trigger),
    .buffer_primed (buffer_primed),
    .trig_rd       (trig_rd.buffer),
    .cc_rd         (cc_rd.buffer)
  );

  trigger_streamer trig_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .trig_peek     (trig_peek),
    .rd            (trig_rd.reader),
    .trig_tdata    (trig_tdata),
    .trig_tvalid   (trig_tvalid),
    .trig_tready   (trig_tready),
    .count_reached (count_reached)
  );

  cc_fft_feeder #(
    .zero_pad (1'b1)  // FFT sees twice the frame length
  ) feeder_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_cc   (start_cc),
    .rd         (cc_rd.reader),
    .cfg_tdata  (cfg_tdata),
    .cfg_tvalid (cfg_tvalid),
    .cfg_tready (cfg_tready),
    .fft_tdata  (fft_tdata),
    .fft_tvalid (fft_tvalid),
    .fft_tready (fft_tready),
    .fft_tlast  (fft_tlast)
  );

endmodule

`default_nettype wire

// ==== bench/cc_capture_props.sv ====
// Assertions bound into the capture top level. They cover stream stability under
// back-pressure, quiet outputs around reset and a single-cycle count_reached.

`timescale 1ns/100ps
`default_nettype none

module cc_capture_props (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     buffer_primed,
  input cc_capture_pkg::sample_t  trig_tdata,
  input logic                     trig_tvalid,
  input logic                     trig_tready,
  input logic                     count_reached,
  input cc_capture_pkg::fft_cfg_t cfg_tdata,
  input logic                     cfg_tvalid,
  input logic                     cfg_tready,
  input cc_capture_pkg::sample_t  fft_tdata,
  input logic                     fft_tvalid,
  input logic                     fft_tready,
  input logic                     fft_tlast
);

  logic [15:0] trig_fails  = '0;  // one counter per property
  logic [15:0] cfg_fails   = '0;
  logic [15:0] fft_fails   = '0;
  logic [15:0] quiet_fails = '0;
  logic [15:0] pulse_fails = '0;
  logic [15:0] fail_total;        // read by the testbench at the end

  assign fail_total = trig_fails + cfg_fails + fft_fails + quiet_fails + pulse_fails;

  trig_hold: assert property (@(posedge clk) disable iff (!rst_n)
    trig_tvalid && !trig_tready |=> trig_tvalid && $stable(trig_tdata))
    else begin
      trig_fails = trig_fails + 16'd1;
      $error("trigger beat changed while stalled");
    end

  cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_tvalid && !cfg_tready |=> cfg_tvalid && $stable(cfg_tdata))
    else begin
      cfg_fails = cfg_fails + 16'd1;
      $error("config beat changed while stalled");
    end

  fft_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fft_tvalid && !fft_tready |=> fft_tvalid && $stable(fft_tdata) && $stable(fft_tlast))
    else begin
      fft_fails = fft_fails + 16'd1;
      $error("fft beat changed while stalled");
    end

  // in reset, at release and one cycle on
  quiet_reset: assert property (@(posedge clk)
    (!rst_n || !$past(rst_n) || !$past(rst_n, 2)) |->
      !(buffer_primed || trig_tvalid || count_reached || cfg_tvalid || fft_tvalid || fft_tlast))
    else begin
      quiet_fails = quiet_fails + 16'd1;
      $error("output active during or right after reset");
    end

  single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    count_reached |=> !count_reached)
    else begin
      pulse_fails = pulse_fails + 16'd1;
      $error("count_reached held for two cycles");
    end

endmodule

bind cc_capture_top cc_capture_props props_i (.*);

`default_nettype wire

// ==== bench/cc_capture_tb.sv ====
// Testbench for the capture channel. Replays the stimulus file, plays the FFT core
// and the trigger consumer, and checks both streams against a model of the buffer.

`timescale 1ns/100ps
`default_nettype none

`include "cc_capture_cfg.svh"

module cc_capture_tb;

  localparam int depth = `CC_RB_DEPTH;
  localparam logic [23:0] exp_cfg = {7'd0, `CC_SCALE_SCHED, `CC_FWD};  // pad, scale, dir

  logic                     clk;
  logic                     rst_n;
  cc_capture_pkg::sample_t  sample_data;
  logic                     sample_valid;
  logic                     trigger;
  logic                     buffer_primed;
  logic                     trig_peek;
  cc_capture_pkg::sample_t  trig_tdata;
  logic                     trig_tvalid;
  logic                     trig_tready;
  logic                     count_reached;
  logic                     start_cc;
  cc_capture_pkg::fft_cfg_t cfg_tdata;
  logic                     cfg_tvalid;
  logic                     cfg_tready;
  cc_capture_pkg::sample_t  fft_tdata;
  logic                     fft_tvalid;
  logic                     fft_tready;
  logic                     fft_tlast;

  integer seed = 49;
  int     errors = 0;
  int     n_lines = 0;       // stimulus lines, sizes the watchdog
  int     writes = 0;        // accepted writes since reset
  bit     frozen_m = 1'b0;   // model of the freeze flag
  int     peeks = 0;
  int     ccs = 0;
  int     pulses = 0;        // count_reached pulses seen
  int     tlasts = 0;        // accepted tlast beats
  int     beats_at_pulse = 0;
  cc_capture_pkg::sample_t model_q[$];  // last depth accepted samples, oldest first
  cc_capture_pkg::sample_t trig_q[$];
  cc_capture_pkg::sample_t fft_q[$];
  logic                    last_q[$];
  logic [23:0]             cfg_q[$];

  cc_capture_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // FFT core and trigger consumer, ready about 3 of 4 cycles
  initial begin : consumers
    int cfg_wait;
    cfg_wait    = 0;
    trig_tready = 1'b0;
    fft_tready  = 1'b0;
    cfg_tready  = 1'b0;
    forever begin
      @(posedge clk);
      #10;
      trig_tready = ($random(seed) & 3) != 0;
      fft_tready  = ($random(seed) & 3) != 0;
      if (cfg_tvalid && cfg_wait < 3) begin
        cfg_wait   = cfg_wait + 1;  // hold off the config beat
        cfg_tready = 1'b0;
      end else begin
        cfg_tready = cfg_tvalid;
        if (!cfg_tvalid) cfg_wait = 0;
      end
    end
  end

  // record beats at the falling edge, where all outputs have settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (trig_tvalid && trig_tready) trig_q.push_back(trig_tdata);
      if (cfg_tvalid && cfg_tready) cfg_q.push_back(cfg_tdata);
      if (fft_tvalid && fft_tready) begin
        fft_q.push_back(fft_tdata);
        last_q.push_back(fft_tlast);
        if (fft_tlast) tlasts = tlasts + 1;
      end
      if (count_reached) begin
        pulses         = pulses + 1;
        beats_at_pulse = trig_q.size();  // beats delivered before the pulse
      end
    end
  end

  task automatic report_mismatch(input string msg);
    errors = errors + 1;
    $display("FAIL @ %0t: %s", $time, msg);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic write_sample(input cc_capture_pkg::sample_t s);
    if (buffer_primed !== (writes >= depth))
      report_mismatch($sformatf("buffer_primed %b after %0d writes", buffer_primed, writes));
    sample_data  = s;
    sample_valid = 1'b1;
    next_cycle();
    sample_valid = 1'b0;
    if (!frozen_m) begin
      writes = writes + 1;
      model_q.push_back(s);
      if (model_q.size() > depth) void'(model_q.pop_front());
    end
  endtask

  task automatic wait_done(input bit trig_path, input int target);
    int n;
    n = 0;
    while ((trig_path ? pulses : tlasts) < target && n < 16 * depth) begin
      next_cycle();
      n = n + 1;
    end
    if ((trig_path ? pulses : tlasts) < target) begin
      errors = errors + 1;
      $display("timed out waiting for the end of the %s stream", trig_path ? "trigger" : "FFT");
    end
  endtask

  task automatic run_peek();
    int start;
    int target;
    start     = trig_q.size();
    target    = pulses + 1;
    trig_peek = 1'b1;
    next_cycle();
    trig_peek = 1'b0;
    wait_done(1'b1, target);
    next_cycle();
    next_cycle();
    if (pulses != target)
      report_mismatch($sformatf("count_reached pulsed %0d times", pulses - target + 1));
    if (beats_at_pulse - start != depth)
      report_mismatch($sformatf("count_reached after %0d beats", beats_at_pulse - start));
    if (trig_q.size() - start != depth)
      report_mismatch($sformatf("%0d trigger beats, expected %0d", trig_q.size() - start, depth));
    else
      for (int i = 0; i < depth; i++)
        if (trig_q[start + i] !== model_q[i])
          report_mismatch($sformatf("trigger beat %0d is %h, expected %h",
                                    i, trig_q[start + i], model_q[i]));
    peeks = peeks + 1;
  endtask

  task automatic run_cc();
    int start;
    int cfg_start;
    int target;
    cc_capture_pkg::sample_t exp;
    start     = fft_q.size();
    cfg_start = cfg_q.size();
    target    = tlasts + 1;
    start_cc  = 1'b1;
    next_cycle();
    start_cc = 1'b0;
    wait_done(1'b0, target);
    if (cfg_q.size() != cfg_start + 1)
      report_mismatch($sformatf("%0d config beats, expected 1", cfg_q.size() - cfg_start));
    else if (cfg_q[cfg_start] !== exp_cfg)
      report_mismatch($sformatf("config word %h, expected %h", cfg_q[cfg_start], exp_cfg));
    if (fft_q.size() - start != 2 * depth)
      report_mismatch($sformatf("%0d fft beats, expected %0d", fft_q.size() - start, 2 * depth));
    else
      for (int i = 0; i < 2 * depth; i++) begin
        exp = (i < depth) ? model_q[i] : '0;  // frame, then zero padding
        if (fft_q[start + i] !== exp || last_q[start + i] !== (i == 2 * depth - 1))
          report_mismatch($sformatf("fft beat %0d is %h last %b, expected %h",
                                    i, fft_q[start + i], last_q[start + i], exp));
      end
    frozen_m = 1'b0;  // cc session released the frame
    ccs      = ccs + 1;
  endtask

  initial begin : main
    integer fd;
    integer rc;
    string  cmd;
    string  line;
    int     arg_a;
    cc_capture_pkg::sample_t arg_b;
    rst_n        = 1'b0;
    sample_data  = '0;
    sample_valid = 1'b0;
    trigger      = 1'b0;
    trig_peek    = 1'b0;
    start_cc     = 1'b0;
    fd = $fopen("bench/cc_capture_stimulus.txt", "r");
    while (fd != 0 && !$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0) n_lines = n_lines + 1;
    end
    if (fd != 0) $fclose(fd);
    fd = $fopen("bench/cc_capture_stimulus.txt", "r");
    if (fd == 0) begin
      errors = errors + 1;
      $display("could not open the stimulus file");
    end
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
    while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
      case (cmd)
        "#": rc = $fgets(line, fd);  // comment line
        "S": begin
          rc = $fscanf(fd, "%h", arg_b);
          write_sample(arg_b);
        end
        "F": begin
          rc = $fscanf(fd, "%d %h", arg_a, arg_b);
          for (int i = 0; i < arg_a; i++) write_sample(arg_b + i);  // ramp
        end
        "W": begin
          rc = $fscanf(fd, "%d", arg_a);
          repeat (arg_a) next_cycle();
        end
        "T": begin
          trigger = 1'b1;
          next_cycle();
          trigger = 1'b0;
          if (writes >= depth) frozen_m = 1'b1;  // unprimed trigger is ignored
        end
        "P": run_peek();
        "C": run_cc();
        default: begin
          errors = errors + 1;
          $display("unknown stimulus command %s", cmd);
        end
      endcase
    end
    if (fd != 0) $fclose(fd);
    next_cycle();
    next_cycle();
    if (trig_q.size() != peeks * depth || fft_q.size() != ccs * 2 * depth
        || cfg_q.size() != ccs) begin
      errors = errors + 1;
      $display("stream beats were seen outside the peek and cc runs");
    end
    $display("check errors: %0d, assertion failures: %0d", errors, dut_i.props_i.fail_total);
    if (errors == 0 && dut_i.props_i.fail_total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    wait (n_lines > 0);
    repeat ((n_lines + 4 * depth) * 8) @(posedge clk);
    $display("watchdog: the stimulus did not finish in the expected time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/cc_capture_stimulus.txt ====
# cmd args: S <hex sample> | F <count> <hex base> | W <idle cycles>
# T trigger, P trigger peek and check, C start cc and check the FFT beats
F 40 a0000000
W 3
T
F 30 b0000000
S c0ffee01
T
P
S dead0001
S dead0002
P
C
F 20 d0000000
T
P
C
W 4

// ==== sources.f ====
+incdir+source
source/cc_capture_pkg.sv
source/frame_rd_if.sv
source/sample_ring_buffer.sv
source/trigger_streamer.sv
source/cc_fft_feeder.sv
source/cc_capture_top.sv
bench/cc_capture_props.sv
bench/cc_capture_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = cc_capture_tb
FILELIST   = sources.f
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
